/* design/syn_global_pkg.sv */
/*
  Global constants for the audio clock mux subsystem
  Local bus widths and clock count limits shared by every block
*/

`default_nettype none

package syn_global_pkg;

  // Local bus data word
  localparam int p_lb_data_w = 16;

  // Local bus address
  localparam int p_lb_addr_w = 8;

  // Upper bound on source clocks the mux can handle
  localparam int p_max_clocks = 8;

  // Select field covers every index up to p_max_clocks
  localparam int p_clk_sel_w = 3;

endpackage : syn_global_pkg

`default_nettype wire

/* design/syn_acortex_reg_pkg.sv */
/*
  Register map of the clock mux block in the audio core
  Holds addresses, the unmapped read filler and the control word layout
*/

`default_nettype none

package syn_acortex_reg_pkg;

  // Control register, enable plus clock index
  localparam logic [syn_global_pkg::p_lb_addr_w-1:0] cmux_clk_sel_addr = 8'h10;

  // Status register, switch done flag plus active vector
  localparam logic [syn_global_pkg::p_lb_addr_w-1:0] cmux_status_addr = 8'h11;

  // Returned for reads that hit no register
  localparam logic [syn_global_pkg::p_lb_data_w-1:0] lb_unmapped_data = 16'hdead;

  // Control word, seen either as a bus word or as fields
  typedef union packed
  {
    // Bus view
    logic [syn_global_pkg::p_lb_data_w-1:0] raw;

    // Decoded view
    struct packed
    {
      // Mux enable in the top bit
      logic en;

      // Reserved, always zero
      logic [syn_global_pkg::p_lb_data_w-syn_global_pkg::p_clk_sel_w-2:0] rsvd;

      // Source clock index
      logic [syn_global_pkg::p_clk_sel_w-1:0] sel;
    } field;
  } cmux_ctrl_t;

endpackage : syn_acortex_reg_pkg

`default_nettype wire

/* design/syn_cmux_lb_decode.sv */
/*
  Local bus decode for the clock mux
  Stores the control word and returns control, status or filler on reads
*/

`default_nettype none

module syn_cmux_lb_decode
(
  input  wire logic                                   cr_intf,
  input  wire logic                                   reset,
  input  wire logic [syn_global_pkg::p_lb_addr_w-1:0] lb_addr,
  input  wire logic                                   lb_wr_en,
  input  wire logic [syn_global_pkg::p_lb_data_w-1:0] lb_wr_data,
  input  wire logic                                   lb_rd_en,
  input  wire logic [syn_global_pkg::p_lb_data_w-1:0] status_word,
  output      logic                                   lb_wr_valid,
  output      logic                                   lb_rd_valid,
  output      logic [syn_global_pkg::p_lb_data_w-1:0] lb_rd_data,
  output      syn_acortex_reg_pkg::cmux_ctrl_t        ctrl_word
);

  // Write word with reserved bits forced low
  logic [syn_global_pkg::p_lb_data_w-1:0] wr_word;

  // Read mux output, registered below
  logic [syn_global_pkg::p_lb_data_w-1:0] rd_word;

  // Keep enable and select, zero the rest
  assign wr_word = {lb_wr_data[syn_global_pkg::p_lb_data_w-1],
                    {(syn_global_pkg::p_lb_data_w-syn_global_pkg::p_clk_sel_w-1){1'b0}},
                    lb_wr_data[syn_global_pkg::p_clk_sel_w-1:0]};

  // Address decode for reads
  always_comb
  begin
    case (lb_addr)
      syn_acortex_reg_pkg::cmux_clk_sel_addr: rd_word = ctrl_word.raw;
      syn_acortex_reg_pkg::cmux_status_addr:  rd_word = status_word;
      default:                                rd_word = syn_acortex_reg_pkg::lb_unmapped_data;
    endcase
  end

  // Control register and handshake flags
  always_ff @(posedge cr_intf)
  begin
    if (reset)
    begin
      ctrl_word.raw <= '0;
      lb_wr_valid   <= 1'b0;
      lb_rd_valid   <= 1'b0;
    end
    else
    begin
      // Only the control address is writable
      if (lb_wr_en && (lb_addr == syn_acortex_reg_pkg::cmux_clk_sel_addr))
      begin
        ctrl_word.raw <= wr_word;
      end
      // One cycle acknowledge, no back-pressure
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
    end
  end

  // Read data, valid alongside lb_rd_valid
  always_ff @(posedge cr_intf)
  begin
    if (lb_rd_en)
    begin
      lb_rd_data <= rd_word;
    end
  end

  // Each write acknowledged on the following cycle
  a_wr_ack: assert property (
    @(posedge cr_intf) disable iff (reset)
    lb_wr_en |=> lb_wr_valid
  );

endmodule : syn_cmux_lb_decode

`default_nettype wire

/* design/syn_clk_mux_core.sv */
/*
  Glitch free clock mux core
  One-hot enable, per source synchronizers and exclusive gating onto mclk
*/

`default_nettype none

module syn_clk_mux_core
#(
  parameter int p_num_clocks = 4
)
(
  input  wire logic                            cr_intf,
  input  wire logic                            reset,
  input  wire syn_acortex_reg_pkg::cmux_ctrl_t ctrl_word,
  input  wire logic [p_num_clocks-1:0]         clk_vec,
  output      logic [p_num_clocks-1:0]         req_vec,
  output      logic [p_num_clocks-1:0]         active_vec,
  output      logic                            mclk
);

  // One-hot over the full select range
  logic [syn_global_pkg::p_max_clocks-1:0] full_onehot;

  // Some other source still holds the gate
  logic [p_num_clocks-1:0] other_active;

  // Source clocks masked by their gates
  logic [p_num_clocks-1:0] gated_vec;

  // Enable 0 leaves all select bits clear
  always_comb
  begin
    full_onehot = '0;
    full_onehot[ctrl_word.field.sel] = ctrl_word.field.en;
  end

  // Indices at or above p_num_clocks drop out here
  assign req_vec = full_onehot[p_num_clocks-1:0];

  for (genvar i = 0; i < p_num_clocks; i++)
  begin : g_src
    // Mask that removes this source from the gate vector
    localparam logic [p_num_clocks-1:0] self_bit = 1 << i;

    logic meta_q;
    logic sync_q;
    logic gate_q;

    // Any gate other than ours
    assign other_active[i] = |(active_vec & ~self_bit);

    // Two flop synchronizer in this source's domain
    always_ff @(posedge clk_vec[i])
    begin
      if (reset)
      begin
        meta_q <= 1'b0;
        sync_q <= 1'b0;
      end
      else
      begin
        meta_q <= req_vec[i];
        sync_q <= meta_q;
      end
    end

    // Gate flop moves on the falling edge while the clock is low
    // Opens only after every other gate has closed
    always_ff @(negedge clk_vec[i])
    begin
      if (reset)
      begin
        gate_q <= 1'b0;
      end
      else
      begin
        gate_q <= sync_q & ~other_active[i];
      end
    end

    assign active_vec[i] = gate_q;
  end : g_src

  // Gate each source by its own flop
  assign gated_vec = clk_vec & active_vec;

  // At most one gate open, so OR is the mux
  assign mclk = |gated_vec;

  // Request is never more than one-hot
  a_req_onehot: assert property (
    @(posedge cr_intf) disable iff (reset)
    $onehot0(req_vec)
  );

endmodule : syn_clk_mux_core

`default_nettype wire

/* design/syn_clk_status.sv */
/*
  Clock switch status
  Brings the gate vector into cr_intf and flags a finished switch
*/

`default_nettype none

module syn_clk_status
#(
  parameter int p_num_clocks = 4
)
(
  input  wire logic                                   cr_intf,
  input  wire logic                                   reset,
  input  wire logic [p_num_clocks-1:0]                req_vec,
  input  wire logic [p_num_clocks-1:0]                active_vec,
  output      logic [syn_global_pkg::p_lb_data_w-1:0] status_word
);

  // Two stage resync of the gate vector
  logic [p_num_clocks-1:0] active_meta;
  logic [p_num_clocks-1:0] active_sync;

  // Gates match the request
  logic switch_done;

  always_ff @(posedge cr_intf)
  begin
    if (reset)
    begin
      active_meta <= '0;
      active_sync <= '0;
    end
    else
    begin
      active_meta <= active_vec;
      active_sync <= active_meta;
    end
  end

  assign switch_done = (active_sync == req_vec);

  // Done flag on top, active vector in the low bits
  assign status_word = {switch_done,
                        {(syn_global_pkg::p_lb_data_w-p_num_clocks-1){1'b0}},
                        active_sync};

  // Gates of different domains never overlap
  a_active_onehot: assert property (
    @(posedge cr_intf) disable iff (reset)
    $onehot0(active_sync)
  );

endmodule : syn_clk_status

`default_nettype wire

/* design/syn_clk_mux.sv */
/*
  Codec master clock selector
  Bus decode, glitch free mux core and switch status
*/

`default_nettype none

module syn_clk_mux
#(
  parameter int p_num_clocks = 4
)
(
  input  wire logic                                   cr_intf,
  input  wire logic                                   reset,
  input  wire logic [syn_global_pkg::p_lb_addr_w-1:0] lb_addr,
  input  wire logic                                   lb_wr_en,
  input  wire logic [syn_global_pkg::p_lb_data_w-1:0] lb_wr_data,
  input  wire logic                                   lb_rd_en,
  input  wire logic [p_num_clocks-1:0]                clk_vec,
  output      logic                                   lb_wr_valid,
  output      logic                                   lb_rd_valid,
  output      logic [syn_global_pkg::p_lb_data_w-1:0] lb_rd_data,
  output      logic                                   mclk
);

  syn_acortex_reg_pkg::cmux_ctrl_t        ctrl_word;
  logic [syn_global_pkg::p_lb_data_w-1:0] status_word;
  logic [p_num_clocks-1:0]                req_vec;
  logic [p_num_clocks-1:0]                active_vec;

  // Register access
  syn_cmux_lb_decode u_decode
  (
    .cr_intf     (cr_intf),
    .reset       (reset),
    .lb_addr     (lb_addr),
    .lb_wr_en    (lb_wr_en),
    .lb_wr_data  (lb_wr_data),
    .lb_rd_en    (lb_rd_en),
    .status_word (status_word),
    .lb_wr_valid (lb_wr_valid),
    .lb_rd_valid (lb_rd_valid),
    .lb_rd_data  (lb_rd_data),
    .ctrl_word   (ctrl_word)
  );

  // Mux proper
  syn_clk_mux_core #(.p_num_clocks(p_num_clocks)) u_core
  (
    .cr_intf    (cr_intf),
    .reset      (reset),
    .ctrl_word  (ctrl_word),
    .clk_vec    (clk_vec),
    .req_vec    (req_vec),
    .active_vec (active_vec),
    .mclk       (mclk)
  );

  // Switch completion back in cr_intf
  syn_clk_status #(.p_num_clocks(p_num_clocks)) u_status
  (
    .cr_intf     (cr_intf),
    .reset       (reset),
    .req_vec     (req_vec),
    .active_vec  (active_vec),
    .status_word (status_word)
  );

endmodule : syn_clk_mux

`default_nettype wire

/* verification/syn_clk_mux_checker.sv */
/*
  Checker for the clock mux testbench
  Compares bus reads and acknowledges, follows mclk and flags runt pulses
*/

`default_nettype none

module syn_clk_mux_checker
#(
  parameter int p_num_clocks = 4
)
(
  input  wire logic                    cr_intf,
  input  wire logic                    reset,
  input  wire logic                    lb_wr_en,
  input  wire logic                    lb_rd_en,
  input  wire logic                    lb_wr_valid,
  input  wire logic                    lb_rd_valid,
  input  wire logic [15:0]             lb_rd_data,
  input  wire logic [p_num_clocks-1:0] clk_vec,
  input  wire logic                    mclk,
  input  wire logic                    exp_on,
  input  wire logic [3:0]              exp_id,
  input  wire logic [15:0]             exp_data,
  input  wire logic [1:0]              mon_mode,
  input  wire logic [2:0]              mon_src,
  output int                           mism_cnt,
  output int                           other_cnt
);

  timeunit 1ns;
  timeprecision 100ps;

  // Shortest source half period
  localparam real min_gap_ns = 10.0;
  localparam real tol_ns     = 1.0;

  // Access seen at the last rising edge
  logic        pend_wr;
  logic        pend_rd;
  logic        pend_chk;
  logic [3:0]  pend_id;
  logic [15:0] pend_exp;
  logic        armed;
  real         rise_t;
  real         fall_t;

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd0:    return "ctrl_readback";
      4'd1:    return "unmapped_read";
      4'd2:    return "switch_status";
      4'd3:    return "mclk_follow";
      4'd4:    return "mclk_low";
      default: return "unknown";
    endcase
  endfunction

  function automatic real half_period(input int idx);
    case (idx)
      0:       return 10.0;
      1:       return 15.0;
      2:       return 25.0;
      default: return 35.0;
    endcase
  endfunction

  // High pulse must match one source half period
  function automatic logic width_ok(input real w);
    logic ok;
    ok = 1'b0;
    for (int i = 0; i < p_num_clocks; i++)
    begin
      if ((w - half_period(i)) <= tol_ns && (half_period(i) - w) <= tol_ns)
        ok = 1'b1;
    end
    return ok;
  endfunction

  initial
  begin
    armed  = 1'b0;
    rise_t = 0.0;
    fall_t = 0.0;
  end

  always @(posedge cr_intf)
  begin
    pend_wr  <= lb_wr_en;
    pend_rd  <= lb_rd_en;
    pend_chk <= exp_on;
    pend_id  <= exp_id;
    pend_exp <= exp_data;
  end

  // Registered outputs are settled at the falling edge
  always @(negedge cr_intf)
  begin
    if (!reset)
    begin
      armed = 1'b1;
      if (pend_wr && lb_wr_valid !== 1'b1)
      begin
        $display("ERROR: write got no lb_wr_valid one cycle later at %0t", $time);
        other_cnt++;
      end
      if (!pend_wr && lb_wr_valid !== 1'b0)
      begin
        $display("ERROR: lb_wr_valid pulsed without a write at %0t", $time);
        other_cnt++;
      end
      if (pend_rd && lb_rd_valid !== 1'b1)
      begin
        $display("ERROR: read got no lb_rd_valid one cycle later at %0t", $time);
        other_cnt++;
      end
      if (!pend_rd && lb_rd_valid !== 1'b0)
      begin
        $display("ERROR: lb_rd_valid pulsed without a read at %0t", $time);
        other_cnt++;
      end
      if (pend_rd && pend_chk && lb_rd_valid === 1'b1 && lb_rd_data !== pend_exp)
      begin
        $display("MISMATCH %s expected %h actual %h", test_name(pend_id), pend_exp, lb_rd_data);
        mism_cnt++;
      end
      // Disabled or out of range, mclk parked low
      if (mon_mode == 2'd2 && mclk !== 1'b0)
      begin
        $display("MISMATCH %s expected 0 actual %b", test_name(4'd4), mclk);
        mism_cnt++;
      end
    end
  end

  // Pulse and gap widths on every mclk edge
  always @(mclk)
  begin
    if (armed)
    begin
      if (mclk === 1'b1)
      begin
        rise_t = $realtime;
        if (rise_t - fall_t < min_gap_ns - 0.01)
        begin
          $display("ERROR: mclk low gap of %0.1f ns is under 10 ns", rise_t - fall_t);
          other_cnt++;
        end
        if (mon_mode == 2'd2)
        begin
          $display("ERROR: mclk rose at %0t while no clock is selected", $time);
          other_cnt++;
        end
      end
      else if (mclk === 1'b0)
      begin
        fall_t = $realtime;
        if (!width_ok(fall_t - rise_t))
        begin
          $display("ERROR: mclk high pulse of %0.1f ns fits no source half period",
                   fall_t - rise_t);
          other_cnt++;
        end
      end
      else
      begin
        $display("ERROR: mclk is unknown at %0t", $time);
        other_cnt++;
      end
    end
  end

  // mclk against the selected source at mid phase
  for (genvar i = 0; i < p_num_clocks; i++)
  begin : g_phase
    always @(clk_vec[i])
    begin
      if (mon_mode == 2'd1 && int'(mon_src) == i)
      begin
        #(half_period(i) / 2.0);
        if (mon_mode == 2'd1 && int'(mon_src) == i && mclk !== clk_vec[i])
        begin
          $display("MISMATCH %s expected %b actual %b", test_name(4'd3), clk_vec[i], mclk);
          mism_cnt++;
        end
      end
    end
  end : g_phase

endmodule : syn_clk_mux_checker

`default_nettype wire

/* verification/syn_clk_mux_tb.sv */
/*
  Testbench for the codec master clock selector
  Runs four source clocks, drives the local bus and walks random control words
*/

`default_nettype none

module syn_clk_mux_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_clocks   = 4;
  localparam int num_switches = 20;
  localparam int poll_limit   = 200;
  localparam int reset_cycles = 5;
  localparam int cr_period    = 40;
  // Worst case per switch, polling plus reads and the mclk window
  localparam int watchdog_ns  =
    (num_switches * (poll_limit + 20) + reset_cycles + 40) * cr_period;

  // Test ids known to the checker
  localparam logic [3:0] id_ctrl     = 4'd0;
  localparam logic [3:0] id_unmapped = 4'd1;
  localparam logic [3:0] id_status   = 4'd2;

  logic                                   cr_intf;
  logic                                   reset;
  logic [syn_global_pkg::p_lb_addr_w-1:0] lb_addr;
  logic                                   lb_wr_en;
  logic [syn_global_pkg::p_lb_data_w-1:0] lb_wr_data;
  logic                                   lb_rd_en;
  logic                                   clk0;
  logic                                   clk1;
  logic                                   clk2;
  logic                                   clk3;
  logic [num_clocks-1:0]                  clk_vec;
  wire logic                              lb_wr_valid;
  wire logic                              lb_rd_valid;
  wire logic [syn_global_pkg::p_lb_data_w-1:0] lb_rd_data;
  wire logic                              mclk;

  // Expectations handed to the checker
  logic        exp_on;
  logic [3:0]  exp_id;
  logic [15:0] exp_data;
  logic [1:0]  mon_mode;
  logic [2:0]  mon_src;

  int          mism_cnt;
  int          other_cnt;
  int          tb_err;
  logic [31:0] lcg_state;

  assign clk_vec = {clk3, clk2, clk1, clk0};

  initial
  begin
    cr_intf = 1'b0;
    forever #(cr_period / 2) cr_intf = ~cr_intf;
  end

  // Source clocks, 20, 30, 50 and 70 ns
  initial clk0 = 1'b0;
  always #10 clk0 = ~clk0;
  initial clk1 = 1'b0;
  always #15 clk1 = ~clk1;
  initial clk2 = 1'b0;
  always #25 clk2 = ~clk2;
  initial clk3 = 1'b0;
  always #35 clk3 = ~clk3;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Read-back word, one-hot request and source index for a written word
  function automatic void predict_ctrl(input logic [15:0] wr, output logic [15:0] rb,
                                       output logic [num_clocks-1:0] req, output int src);
    rb  = {wr[15], 12'b0, wr[2:0]};
    req = '0;
    src = -1;
    if (wr[15] && int'(wr[2:0]) < num_clocks)
    begin
      src      = int'(wr[2:0]);
      req[src] = 1'b1;
    end
  endfunction

  task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
    int waited;
    @(negedge cr_intf);
    lb_addr    = addr;
    lb_wr_data = data;
    lb_wr_en   = 1'b1;
    @(negedge cr_intf);
    lb_wr_en = 1'b0;
    waited   = 0;
    // Acknowledge due now, a missing one is reported by the checker
    while (lb_wr_valid !== 1'b1 && waited < 4)
    begin
      @(negedge cr_intf);
      waited++;
    end
  endtask

  task automatic bus_read(input logic [7:0] addr, input logic [3:0] id, input logic chk,
                          input logic [15:0] exp, output logic [15:0] data);
    int waited;
    @(negedge cr_intf);
    lb_addr  = addr;
    lb_rd_en = 1'b1;
    exp_on   = chk;
    exp_id   = id;
    exp_data = exp;
    @(negedge cr_intf);
    lb_rd_en = 1'b0;
    exp_on   = 1'b0;
    waited   = 0;
    while (lb_rd_valid !== 1'b1 && waited < 4)
    begin
      @(negedge cr_intf);
      waited++;
    end
    data = lb_rd_data;
  endtask

  initial
  begin
    logic [15:0]           word;
    logic [15:0]           rb_exp;
    logic [num_clocks-1:0] req_exp;
    logic [15:0]           rd;
    logic [7:0]            addr;
    int                    src;
    int                    cycles;
    reset      = 1'b1;
    lb_addr    = '0;
    lb_wr_en   = 1'b0;
    lb_wr_data = '0;
    lb_rd_en   = 1'b0;
    exp_on     = 1'b0;
    exp_id     = '0;
    exp_data   = '0;
    mon_mode   = 2'd0;
    mon_src    = '0;
    tb_err     = 0;
    lcg_state  = 32'h13e7e8ba;
    repeat (reset_cycles) @(negedge cr_intf);
    reset = 1'b0;

    // Unmapped reads, fixed corners then random addresses
    bus_read(8'h00, id_unmapped, 1'b1, 16'hdead, rd);
    bus_read(8'h12, id_unmapped, 1'b1, 16'hdead, rd);
    bus_read(8'hff, id_unmapped, 1'b1, 16'hdead, rd);
    for (int k = 0; k < 4; k++)
    begin
      lcg_state = lcg_next(lcg_state);
      addr      = lcg_state[23:16];
      if (addr == syn_acortex_reg_pkg::cmux_clk_sel_addr ||
          addr == syn_acortex_reg_pkg::cmux_status_addr)
      begin
        addr = addr ^ 8'h80;
      end
      bus_read(addr, id_unmapped, 1'b1, 16'hdead, rd);
    end

    for (int i = 0; i < num_switches; i++)
    begin
      // Select walks 0 to 7, enable and reserved bits random
      lcg_state = lcg_next(lcg_state);
      word      = lcg_state[31:16];
      word[2:0] = i[2:0];
      if (i < 2)
      begin
        word[15] = i[0];
      end
      predict_ctrl(word, rb_exp, req_exp, src);
      bus_write(syn_acortex_reg_pkg::cmux_clk_sel_addr, word);
      bus_read(syn_acortex_reg_pkg::cmux_clk_sel_addr, id_ctrl, 1'b1, rb_exp, rd);
      cycles = 0;
      rd     = '0;
      // Poll switch_done
      while (!rd[15] && cycles < poll_limit)
      begin
        bus_read(syn_acortex_reg_pkg::cmux_status_addr, id_status, 1'b0, '0, rd);
        cycles += 2;
      end
      if (!rd[15])
      begin
        $display("ERROR: switch %0d did not finish within %0d cycles", i, poll_limit);
        tb_err++;
      end
      bus_read(syn_acortex_reg_pkg::cmux_status_addr, id_status, 1'b1,
               {1'b1, {(15 - num_clocks){1'b0}}, req_exp}, rd);
      // Watch mclk while the selection is settled
      mon_src  = (src >= 0) ? src[2:0] : 3'd0;
      mon_mode = (src >= 0) ? 2'd1 : 2'd2;
      repeat (8) @(negedge cr_intf);
      mon_mode = 2'd0;
    end

    $display("Error counts: %0d mismatches, %0d other errors", mism_cnt, other_cnt + tb_err);
    if (mism_cnt == 0 && other_cnt == 0 && tb_err == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(watchdog_ns);
    $display("ERROR: watchdog expired after %0d ns, the test did not finish", watchdog_ns);
    $display("Error counts: %0d mismatches, %0d other errors", mism_cnt, other_cnt + tb_err + 1);
    $display("Simulation failed");
    $finish;
  end

  syn_clk_mux #(.p_num_clocks(num_clocks)) dut
  (
    .cr_intf     (cr_intf),
    .reset       (reset),
    .lb_addr     (lb_addr),
    .lb_wr_en    (lb_wr_en),
    .lb_wr_data  (lb_wr_data),
    .lb_rd_en    (lb_rd_en),
    .clk_vec     (clk_vec),
    .lb_wr_valid (lb_wr_valid),
    .lb_rd_valid (lb_rd_valid),
    .lb_rd_data  (lb_rd_data),
    .mclk        (mclk)
  );

  syn_clk_mux_checker #(.p_num_clocks(num_clocks)) u_checker
  (
    .cr_intf     (cr_intf),
    .reset       (reset),
    .lb_wr_en    (lb_wr_en),
    .lb_rd_en    (lb_rd_en),
    .lb_wr_valid (lb_wr_valid),
    .lb_rd_valid (lb_rd_valid),
    .lb_rd_data  (lb_rd_data),
    .clk_vec     (clk_vec),
    .mclk        (mclk),
    .exp_on      (exp_on),
    .exp_id      (exp_id),
    .exp_data    (exp_data),
    .mon_mode    (mon_mode),
    .mon_src     (mon_src),
    .mism_cnt    (mism_cnt),
    .other_cnt   (other_cnt)
  );

endmodule : syn_clk_mux_tb

`default_nettype wire

/* syn_clk_mux.f */
design/syn_global_pkg.sv
design/syn_acortex_reg_pkg.sv
design/syn_cmux_lb_decode.sv
design/syn_clk_mux_core.sv
design/syn_clk_status.sv
design/syn_clk_mux.sv
verification/syn_clk_mux_checker.sv
verification/syn_clk_mux_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the clock mux testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
bin=syn_clk_mux_sim

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  --top-module syn_clk_mux_tb --Mdir obj_dir -o "$bin" -f syn_clk_mux.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$bin" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation completed successfully" "$log"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
